//--- design/mm2s_cfg.svh
`ifndef MM2S_CFG_SVH
`define MM2S_CFG_SVH

////////////////////
// Pixel format
////////////////////

// Bits per pixel
`define MM2S_PIXEL_WIDTH 8
// Pixels packed in one memory beat
`define MM2S_LANES 4

////////////////////
// AXI master
////////////////////

`define MM2S_ADDR_WIDTH 32
`define MM2S_DATA_WIDTH 32
// Beats in a full burst
`define MM2S_BURST_LEN 16

////////////////////
// Image and buffer
////////////////////

// Width and height counters
`define MM2S_IMG_BITS 12
// FIFO depth in four-lane words
`define MM2S_FIFO_WORDS 64

`endif

//--- design/mm2s_pkg.sv
`include "mm2s_cfg.svh"

package mm2s_pkg;

	// One pixel
	typedef logic [`MM2S_PIXEL_WIDTH-1:0] pixel_t;

	// Tagged pixel
	// Pixel in the low bits, then sof, eol on top
	typedef logic [`MM2S_PIXEL_WIDTH+1:0] lane_t;

	// Byte address on the AR channel
	typedef logic [`MM2S_ADDR_WIDTH-1:0] addr_t;

	// Image width or height
	typedef logic [`MM2S_IMG_BITS-1:0] dim_t;

	// Free words in the FIFO, 0 up to full depth
	typedef logic [$clog2(`MM2S_FIFO_WORDS+1)-1:0] count_t;

	// Read data word
	// Byte 0 sits in the lowest bits
	typedef union packed {
		logic [`MM2S_DATA_WIDTH-1:0] raw;
		pixel_t [`MM2S_LANES-1:0] px;
	} beat_u;

endpackage

//--- design/mm2s_frame_reader.sv
`timescale 1ns/1ps
`include "mm2s_cfg.svh"

module mm2s_frame_reader (
	input logic f2s_aclk,
	input logic reset,
	input logic soft_reset,
	input logic fsync,
	input mm2s_pkg::addr_t base_addr,
	input mm2s_pkg::dim_t img_width,
	input mm2s_pkg::dim_t img_height,
	output logic r_sof,
	output logic resetting,
	output mm2s_pkg::addr_t araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input logic arready,
	input mm2s_pkg::beat_u rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready,
	output mm2s_pkg::beat_u beat,
	output logic beat_sof,
	output logic beat_eol,
	output logic wr_en,
	input mm2s_pkg::count_t free_words
);

	localparam int BEAT_BYTES = `MM2S_DATA_WIDTH / 8;
	localparam int LANE_SHIFT = $clog2(`MM2S_LANES);
	localparam int BURST_LEN = `MM2S_BURST_LEN;
	localparam int TOTAL_BITS = 2 * `MM2S_IMG_BITS;

	// FSM encoding
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ADDR = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_FLUSH = 2'd3;

	logic [1:0] state;
	logic abort;
	logic accept;
	logic frame_done;
	mm2s_pkg::dim_t line_beats_in;
	mm2s_pkg::dim_t beats_per_line;
	mm2s_pkg::dim_t line_beat;
	mm2s_pkg::dim_t lines_left;
	logic [TOTAL_BITS-1:0] beats_left;
	logic first_beat;

	// Soft reset takes effect in the same cycle
	assign abort = soft_reset | resetting;
	// Frame start only from idle
	assign accept = (state == S_IDLE) && fsync && !abort;
	// Four pixels per beat
	assign line_beats_in = img_width >> LANE_SHIFT;

	// Fixed burst shape
	assign arsize = 3'($clog2(BEAT_BYTES));
	assign arburst = 2'b01;

	////////////////////
	// R channel to FIFO
	////////////////////

	// Ready while a burst is open, also when discarding
	assign rready = (state == S_DATA) || (state == S_FLUSH);
	// Data of an aborted burst is dropped
	assign wr_en = (state == S_DATA) && rvalid;
	assign beat = rdata;
	assign beat_sof = first_beat;
	assign beat_eol = (line_beat == '0);
	// Last beat of the last line
	assign frame_done = beat_eol && (lines_left == mm2s_pkg::dim_t'(1));

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge f2s_aclk) begin
		if (reset) begin
			state <= S_IDLE;
			arvalid <= 1'b0;
			r_sof <= 1'b0;
			resetting <= 1'b0;
		end else begin
			// One-cycle pulse after fsync is taken
			r_sof <= accept;

			// Held until the FSM is back in idle
			if (soft_reset) begin
				resetting <= 1'b1;
			end else if (state == S_IDLE) begin
				resetting <= 1'b0;
			end

			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_ADDR;
					end
				end
				S_ADDR: begin
					if (arvalid) begin
						// Request must complete even on abort
						if (arready) begin
							arvalid <= 1'b0;
							state <= abort ? S_FLUSH : S_DATA;
						end
					end else if (abort || beats_left == '0) begin
						state <= S_IDLE;
					end else if (free_words >= BURST_LEN) begin
						// Whole burst fits, R never stalls
						arvalid <= 1'b1;
					end
				end
				S_DATA: begin
					if (rvalid && rlast) begin
						state <= (abort || frame_done) ? S_IDLE : S_ADDR;
					end else if (abort) begin
						state <= S_FLUSH;
					end
				end
				default: begin
					// Drain the rest of the open burst
					if (rvalid && rlast) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	////////////////////
	// Frame counters
	////////////////////

	always_ff @(posedge f2s_aclk) begin
		// Latch frame geometry
		if (accept) begin
			araddr <= base_addr;
			beats_per_line <= line_beats_in;
			line_beat <= line_beats_in - 1'b1;
			lines_left <= img_height;
			beats_left <= TOTAL_BITS'(line_beats_in) * TOTAL_BITS'(img_height);
			first_beat <= 1'b1;
		end

		// Full burst or the remainder
		if (state == S_ADDR && !arvalid) begin
			if (beats_left >= BURST_LEN) begin
				arlen <= 8'(BURST_LEN - 1);
			end else begin
				arlen <= 8'(beats_left - 1'b1);
			end
		end

		// Next burst address
		if (arvalid && arready) begin
			araddr <= araddr + mm2s_pkg::addr_t'((arlen + 1) * BEAT_BYTES);
			beats_left <= beats_left - TOTAL_BITS'(arlen + 1);
		end

		// Position in the line, per written beat
		if (wr_en) begin
			first_beat <= 1'b0;
			if (beat_eol) begin
				line_beat <= beats_per_line - 1'b1;
				lines_left <= lines_left - 1'b1;
			end else begin
				line_beat <= line_beat - 1'b1;
			end
		end
	end

endmodule

//--- design/mm2s_pixel_fifo.sv
`timescale 1ns/1ps
`include "mm2s_cfg.svh"

module mm2s_pixel_fifo (
	input logic f2s_aclk,
	input logic reset,
	input logic flush,
	input logic wr_en,
	input mm2s_pkg::lane_t [`MM2S_LANES-1:0] wr_lanes,
	output mm2s_pkg::count_t free_words,
	output logic tvalid,
	output mm2s_pkg::pixel_t tdata,
	output logic tuser,
	output logic tlast,
	input logic tready
);

	localparam int WORDS = `MM2S_FIFO_WORDS;
	localparam int LANES = `MM2S_LANES;
	localparam int PTR_W = $clog2(WORDS);
	localparam int LANE_W = $clog2(LANES);
	localparam int PW = `MM2S_PIXEL_WIDTH;

	mm2s_pkg::lane_t [LANES-1:0] mem [WORDS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LANE_W-1:0] rd_lane;
	mm2s_pkg::count_t used;
	mm2s_pkg::lane_t out_lane;
	logic full;
	logic empty;
	logic push;
	logic load;
	logic word_done;

	assign full = (used == mm2s_pkg::count_t'(WORDS));
	assign empty = (used == '0);
	assign free_words = mm2s_pkg::count_t'(WORDS) - used;

	// Nothing moves during flush
	assign push = wr_en && !full && !flush;
	// Output register empty or being taken
	assign load = (!tvalid || tready) && !empty && !flush;
	// Word freed after its lane 0 is popped
	assign word_done = load && (rd_lane == '0);

	////////////////////
	// Word storage
	////////////////////

	always_ff @(posedge f2s_aclk) begin
		if (push) begin
			mem[wr_ptr] <= wr_lanes;
		end
	end

	always_ff @(posedge f2s_aclk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			rd_lane <= LANE_W'(LANES - 1);
			used <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Lane 3 first, down to lane 0
			if (word_done) begin
				rd_lane <= LANE_W'(LANES - 1);
				rd_ptr <= rd_ptr + 1'b1;
			end else if (load) begin
				rd_lane <= rd_lane - 1'b1;
			end
			used <= used + mm2s_pkg::count_t'(push) - mm2s_pkg::count_t'(word_done);
		end
	end

	////////////////////
	// Stream output
	////////////////////

	always_ff @(posedge f2s_aclk) begin
		if (reset || flush) begin
			tvalid <= 1'b0;
		end else if (load) begin
			tvalid <= 1'b1;
		end else if (tready) begin
			tvalid <= 1'b0;
		end
	end

	// Payload only, valid bit carries the state
	always_ff @(posedge f2s_aclk) begin
		if (load) begin
			out_lane <= mem[rd_ptr][rd_lane];
		end
	end

	// Unpack the tagged lane
	assign tdata = out_lane[PW-1:0];
	assign tuser = out_lane[PW];
	assign tlast = out_lane[PW+1];

endmodule

//--- design/mm2s.sv
`timescale 1ns/1ps
`include "mm2s_cfg.svh"

module mm2s (
	input logic f2s_aclk,
	input logic reset,
	input logic soft_reset,
	output logic resetting,
	input logic fsync,
	input mm2s_pkg::addr_t base_addr,
	input mm2s_pkg::dim_t img_width,
	input mm2s_pkg::dim_t img_height,
	output logic r_sof,
	output mm2s_pkg::addr_t araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input logic arready,
	input mm2s_pkg::beat_u rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready,
	output logic tvalid,
	output mm2s_pkg::pixel_t tdata,
	output logic tuser,
	output logic tlast,
	input logic tready
);

	localparam int PW = `MM2S_PIXEL_WIDTH;
	localparam int LANES = `MM2S_LANES;

	mm2s_pkg::beat_u beat;
	logic beat_sof;
	logic beat_eol;
	logic wr_en;
	mm2s_pkg::count_t free_words;
	mm2s_pkg::lane_t [LANES-1:0] wr_lanes;

	////////////////////
	// Memory side
	////////////////////

	mm2s_frame_reader reader (
		.f2s_aclk(f2s_aclk),
		.reset(reset),
		.soft_reset(soft_reset),
		.fsync(fsync),
		.base_addr(base_addr),
		.img_width(img_width),
		.img_height(img_height),
		.r_sof(r_sof),
		.resetting(resetting),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.beat(beat),
		.beat_sof(beat_sof),
		.beat_eol(beat_eol),
		.wr_en(wr_en),
		.free_words(free_words)
	);

	////////////////////
	// Lane packing
	////////////////////

	// Lane order reversed so lane 3 holds byte 0
	// sof on lane 3, eol on lane 0
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			wr_lanes[i] = {2'b00, beat.px[LANES-1-i]};
		end
		wr_lanes[LANES-1][PW] = beat_sof;
		wr_lanes[0][PW+1] = beat_eol;
	end

	// Flushed while the reader drains
	mm2s_pixel_fifo fifo (
		.f2s_aclk(f2s_aclk),
		.reset(reset),
		.flush(resetting),
		.wr_en(wr_en),
		.wr_lanes(wr_lanes),
		.free_words(free_words),
		.tvalid(tvalid),
		.tdata(tdata),
		.tuser(tuser),
		.tlast(tlast),
		.tready(tready)
	);

endmodule

//--- dv/mm2s_axi_mem.sv
`timescale 1ns/1ps
`include "mm2s_cfg.svh"

module mm2s_axi_mem (
	input logic f2s_aclk,
	input logic reset,
	input mm2s_pkg::addr_t araddr,
	input logic [7:0] arlen,
	input logic arvalid,
	output logic arready,
	output mm2s_pkg::beat_u rdata,
	output logic rlast,
	output logic rvalid,
	input logic rready
);

	// Gap generator state
	logic [31:0] seed = 32'h0b11_5cf3;
	logic arready_q = 1'b0;
	logic rvalid_q = 1'b0;
	logic busy = 1'b0;
	mm2s_pkg::addr_t addr = '0;
	logic [7:0] left = '0;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Memory content, a hash of the whole byte address
	function automatic mm2s_pkg::pixel_t mem_byte(input mm2s_pkg::addr_t a);
		logic [31:0] h;
		h = a * 32'h9e37_79b1;
		h = h ^ (h >> 16);
		return h[7:0];
	endfunction

	assign arready = arready_q;
	assign rvalid = rvalid_q;
	assign rlast = (left == 8'd0);

	// Byte 0 of the beat in the low lane
	always_comb begin
		for (int i = 0; i < `MM2S_LANES; i++) begin
			rdata.px[i] = mem_byte(addr + mm2s_pkg::addr_t'(i));
		end
	end

	////////////////////
	// One burst at a time
	////////////////////

	always @(posedge f2s_aclk) begin
		seed <= lcg_next(seed);
		if (reset) begin
			arready_q <= 1'b0;
			rvalid_q <= 1'b0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (arvalid && arready_q) begin
				busy <= 1'b1;
				addr <= araddr;
				left <= arlen;
				arready_q <= 1'b0;
				rvalid_q <= seed[25] | seed[24];
			end else begin
				// About three cycles in four
				arready_q <= seed[29] | seed[28];
			end
		end else if (rvalid_q && rready) begin
			if (rlast) begin
				busy <= 1'b0;
				rvalid_q <= 1'b0;
			end else begin
				addr <= addr + 32'd4;
				left <= left - 8'd1;
				rvalid_q <= seed[25] | seed[24];
			end
		end else if (!rvalid_q) begin
			rvalid_q <= seed[25] | seed[24];
		end
	end

endmodule

//--- dv/mm2s_assert.sv
`timescale 1ns/1ps

module mm2s_assert (
	input logic f2s_aclk,
	input logic reset,
	input logic resetting,
	input logic r_sof,
	input mm2s_pkg::addr_t araddr,
	input logic [7:0] arlen,
	input logic arvalid,
	input logic arready,
	input logic rready,
	input logic tvalid,
	input logic tready,
	input mm2s_pkg::pixel_t tdata,
	input logic tuser,
	input logic tlast
);

	// AR request held until accepted
	ar_stable: assert property (@(posedge f2s_aclk) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else $error("AR request changed before arready");

	// Stream beat held under back-pressure, flush excepted
	stream_stable: assert property (@(posedge f2s_aclk) disable iff (reset || resetting)
		tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tuser) && $stable(tlast))
		else $error("Stream beat changed before tready");

	// Quiet outputs right after reset
	reset_quiet: assert property (@(posedge f2s_aclk)
		$fell(reset) |-> !arvalid && !rready && !tvalid && !r_sof && !resetting)
		else $error("Output active after reset");

	// Single-cycle frame start
	sof_pulse: assert property (@(posedge f2s_aclk) disable iff (reset)
		r_sof |=> !r_sof)
		else $error("r_sof longer than one cycle");

endmodule

//--- dv/mm2s_tb.sv
`timescale 1ns/1ps
`include "mm2s_cfg.svh"

module mm2s_tb;

	localparam int PW = `MM2S_PIXEL_WIDTH;
	localparam int NUM_FRAMES = 12;
	localparam int MAX_PIXELS = 32 * 8;
	// Twenty cycles per pixel plus margin, four extra frames for stall and soft reset
	localparam int CYCLE_LIMIT = (NUM_FRAMES + 4) * MAX_PIXELS * 20 + 5000;

	logic f2s_aclk = 1'b0;
	logic reset = 1'b1;
	logic soft_reset = 1'b0;
	logic fsync = 1'b0;
	mm2s_pkg::addr_t base_addr = '0;
	mm2s_pkg::dim_t img_width = '0;
	mm2s_pkg::dim_t img_height = '0;
	logic tready = 1'b0;
	logic resetting;
	logic r_sof;
	mm2s_pkg::addr_t araddr;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;
	mm2s_pkg::beat_u rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	logic tvalid;
	mm2s_pkg::pixel_t tdata;
	logic tuser;
	logic tlast;

	// Model state
	logic [31:0] rng = 32'h0b11_5cf3;
	logic [31:0] ready_rng = 32'h0b11_5cf3;
	logic check_en = 1'b0;
	logic resetting_d = 1'b0;
	logic hold_ready = 1'b0;
	logic burst_open = 1'b0;
	int cycles = 0;
	int pix_seen = 0;
	int sof_count = 0;
	int frames_started = 0;
	mm2s_pkg::lane_t pix_q[$];
	mm2s_pkg::addr_t ar_addr_q[$];
	logic [7:0] ar_len_q[$];

	always #50 f2s_aclk = ~f2s_aclk;

	mm2s uut (.*);

	mm2s_axi_mem mem (
		.f2s_aclk(f2s_aclk),
		.reset(reset),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready)
	);

	bind mm2s mm2s_assert chk (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte stored at address a
	function automatic mm2s_pkg::pixel_t expected_byte(input mm2s_pkg::addr_t a);
		logic [31:0] h;
		h = a * 32'h9e37_79b1;
		h = h ^ (h >> 16);
		return h[7:0];
	endfunction

	////////////////////
	// Failure reporting
	////////////////////

	task automatic report_failure();
		$display("Some tests failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_pixel(input string name, input mm2s_pkg::pixel_t got,
			input mm2s_pkg::pixel_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_addr(input string name, input mm2s_pkg::addr_t got,
			input mm2s_pkg::addr_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
			report_failure();
		end
	endtask

	// AR control fields, zero extended
	task automatic check_field(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
			report_failure();
		end
	endtask

	////////////////////
	// Monitors
	////////////////////

	always @(posedge f2s_aclk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run did not finish within %0d cycles", CYCLE_LIMIT);
			report_failure();
		end
	end

	// Back-pressure, ready about three cycles in four
	// Held low while the stall test asks for it
	always @(posedge f2s_aclk) begin
		ready_rng <= lcg_next(ready_rng);
		tready <= !hold_ready && (ready_rng[27] | ready_rng[26]);
	end

	always @(posedge f2s_aclk) begin
		mm2s_pkg::lane_t exp_lane;
		resetting_d <= resetting;
		if (!reset && r_sof) begin
			sof_count <= sof_count + 1;
		end
		// rready exactly while a burst is open
		if (!reset) begin
			check_flag("rready", rready, burst_open);
			if (arvalid && arready) begin
				burst_open <= 1'b1;
			end else if (rvalid && rready && rlast) begin
				burst_open <= 1'b0;
			end
		end
		// tvalid forced low once the flush is in effect
		if (resetting && resetting_d) begin
			check_flag("tvalid", tvalid, 1'b0);
		end
		if (!reset && check_en && tvalid && tready) begin
			if (pix_q.size() == 0) begin
				$display("Stream delivered a pixel that no frame expects");
				report_failure();
			end
			exp_lane = pix_q.pop_front();
			check_pixel("tdata", tdata, exp_lane[PW-1:0]);
			check_flag("tuser", tuser, exp_lane[PW]);
			check_flag("tlast", tlast, exp_lane[PW+1]);
			pix_seen <= pix_seen + 1;
		end
		if (!reset && check_en && arvalid && arready) begin
			if (ar_addr_q.size() == 0) begin
				$display("Reader issued a burst beyond the end of the frame");
				report_failure();
			end
			check_addr("araddr", araddr, ar_addr_q.pop_front());
			check_field("arlen", arlen, ar_len_q.pop_front());
			check_field("arsize", {5'd0, arsize}, 8'd2);
			check_field("arburst", {6'd0, arburst}, 8'd1);
		end
	end

	////////////////////
	// Frame sequencing
	////////////////////

	// Queue the expected stream and bursts, then pulse fsync
	task automatic start_frame(input mm2s_pkg::addr_t base, input mm2s_pkg::dim_t w,
			input mm2s_pkg::dim_t h);
		int remain;
		mm2s_pkg::addr_t a;
		mm2s_pkg::lane_t entry;
		for (int k = 0; k < w * h; k++) begin
			entry[PW-1:0] = expected_byte(base + mm2s_pkg::addr_t'(k));
			entry[PW] = (k == 0);
			entry[PW+1] = ((k % w) == w - 1);
			pix_q.push_back(entry);
		end
		remain = (w / 4) * h;
		a = base;
		while (remain > 0) begin
			ar_addr_q.push_back(a);
			ar_len_q.push_back(8'((remain >= 16 ? 16 : remain) - 1));
			a = a + 32'd64;
			remain = remain - 16;
		end
		@(posedge f2s_aclk);
		fsync <= 1'b1;
		base_addr <= base;
		img_width <= w;
		img_height <= h;
		@(posedge f2s_aclk);
		fsync <= 1'b0;
		frames_started++;
	endtask

	task automatic wait_frame_done();
		while (pix_q.size() != 0 || ar_addr_q.size() != 0) begin
			@(posedge f2s_aclk);
		end
	endtask

	task automatic random_frame();
		mm2s_pkg::dim_t w;
		mm2s_pkg::dim_t h;
		mm2s_pkg::addr_t base;
		rng = lcg_next(rng);
		w = mm2s_pkg::dim_t'(4 * (rng[18:16] + 1));
		h = mm2s_pkg::dim_t'(rng[22:20] + 1);
		rng = lcg_next(rng);
		base = mm2s_pkg::addr_t'({rng[29:16], 2'b00});
		start_frame(base, w, h);
		wait_frame_done();
	endtask

	// Stream stalled, a full frame fills the FIFO
	// The next frame must wait for free space before its bursts
	task automatic backpressure_test();
		mm2s_pkg::addr_t base;
		rng = lcg_next(rng);
		base = mm2s_pkg::addr_t'({rng[29:16], 2'b00});
		hold_ready <= 1'b1;
		start_frame(base, 12'd32, 12'd8);
		while (ar_addr_q.size() != 0) begin
			@(posedge f2s_aclk);
		end
		@(posedge f2s_aclk);
		// Last burst drained, reader back in idle
		while (rready) begin
			@(posedge f2s_aclk);
		end
		rng = lcg_next(rng);
		base = mm2s_pkg::addr_t'({rng[29:16], 2'b00});
		start_frame(base, 12'd32, 12'd4);
		repeat (20) @(posedge f2s_aclk);
		hold_ready <= 1'b0;
		wait_frame_done();
	endtask

	// Abort a full-size frame partway through
	task automatic soft_reset_test();
		int seen_at;
		rng = lcg_next(rng);
		start_frame(mm2s_pkg::addr_t'({rng[29:16], 2'b00}), 12'd32, 12'd8);
		seen_at = pix_seen;
		while (pix_seen < seen_at + 10) begin
			@(posedge f2s_aclk);
		end
		soft_reset <= 1'b1;
		check_en <= 1'b0;
		@(posedge f2s_aclk);
		soft_reset <= 1'b0;
		@(posedge f2s_aclk);
		check_flag("resetting", resetting, 1'b1);
		while (resetting) begin
			@(posedge f2s_aclk);
		end
		pix_q.delete();
		ar_addr_q.delete();
		ar_len_q.delete();
		check_en <= 1'b1;
		// New base, must stream from a clean state
		rng = lcg_next(rng);
		start_frame(mm2s_pkg::addr_t'({rng[29:16], 2'b00} + 32'h0001_0000), 12'd16, 12'd6);
		wait_frame_done();
	endtask

	initial begin
		repeat (10) @(posedge f2s_aclk);
		reset <= 1'b0;
		check_en <= 1'b1;
		repeat (3) @(posedge f2s_aclk);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			random_frame();
		end
		backpressure_test();
		soft_reset_test();
		repeat (5) @(posedge f2s_aclk);
		// One r_sof per accepted fsync
		if (sof_count != frames_started) begin
			$display("ERROR at %0t: r_sof pulses got %0d expected %0d", $time, sof_count,
				frames_started);
			report_failure();
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

//--- project.f
+incdir+design
design/mm2s_pkg.sv
design/mm2s_frame_reader.sv
design/mm2s_pixel_fifo.sv
design/mm2s.sv
dv/mm2s_axi_mem.sv
dv/mm2s_assert.sv
dv/mm2s_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -Wno-fatal --top-module mm2s_tb \
	-f project.f -o mm2s_sim 2>&1 && ./obj_dir/mm2s_sim 2>&1)
echo "$out"
echo "$out" | grep -q "All tests passed" && exit 0 || exit 1
